/* test/control_golden.txt */
// flush_req  instr (decoded_instr_t)  expected ctrl (ctrl_word_t)  expected advance
// One line per clock cycle after reset, every column in hex
// Reset flush: hold, fetch, refill
0 000000000000000 000000000000 0
0 000000000000000 100000000003 0
0 000000000000000 000000000003 1
// dp_imm ADD, dp_imm CMP, dp_reg_imm MOV with RRX
0 0220082a1000000 020558811003 1
0 024015050000000 0200b8028803 1
0 06061a000c00000 0400180b5003 1
// dp_reg_reg ADD with rs and rm on the PC
0 0a3fe8000000000 060000200020 0
0 0a3fe8000000000 040000111043 1
// Pre-index load with writeback, immediate offset
0 0e400000001b010 220200010403 0
0 0e400000001b010 000000012110 0
0 0e400000001b010 0a0000035000 1
// Post-index byte load, down
0 0e6000000005004 220080008603 0
0 0e6000000005004 00000000a114 0
0 0e6000000005004 0a0000035004 1
// Store with up register offset, LSL #2
0 128a00000058000 240000810003 0
0 128a00000058000 080000000008 1
// Load with failed condition, then class other
0 0c400000001b010 000000000003 1
0 160000000000000 000000000003 1
// Flush during step 1 of a load, then dp_reg_reg from step 0
0 0e400000001b010 220200010403 0
1 0e400000001b010 100000000003 0
0 0e400000001b010 000000000003 1
0 0a3fe8000000000 060000200020 0
0 0a3fe8000000000 040000111043 1

/* filelist.f */
+incdir+src
src/cpu_decode_pkg.sv
src/cpu_control_pkg.sv
src/flush_sequencer.sv
src/dataproc_control.sv
src/load_store_control.sv
src/control_sequencer.sv
src/control_unit.sv
test/control_unit_tb.sv

/* Makefile */
SIM      := verilator
TOP      := control_unit_tb
FILELIST := filelist.f
FLAGS    := --binary --timing --assert -j 0 --top-module $(TOP)
OBJ_DIR  := obj_dir

SIM_BIN  := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))
HEADERS  := $(wildcard src/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf $(OBJ_DIR)

/* test/control_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit_tb;

  import cpu_decode_pkg::*;
  import cpu_control_pkg::*;

  localparam int    CLK_PERIOD    = 10;
  localparam int    RESET_CYCLES  = 3;
  localparam int    TIMEOUT_SLACK = 20;
  localparam int    GOLDEN_AW     = 8;
  localparam int    GOLDEN_WORDS  = 1 << GOLDEN_AW;
  localparam int    MAX_VECTORS   = GOLDEN_WORDS / 4;
  localparam int    INSTR_W       = $bits(decoded_instr_t);
  localparam int    CTRL_W        = $bits(ctrl_word_t);
  localparam string GOLDEN_FILE   = "test/control_golden.txt";

  logic           clk;
  logic           reset;
  logic           flush_req;
  decoded_instr_t instr;
  ctrl_word_t     ctrl;
  logic           advance;

  // Four words per cycle: flush_req, instr, ctrl, advance
  logic [63:0] golden_mem [0:GOLDEN_WORDS-1];

  int vec_count      = 0;
  int cycle_cnt      = 0;
  int cycle_limit    = 0;
  int ctrl_errors    = 0;
  int advance_errors = 0;
  int file_errors    = 0;

  control_unit dut_i (
    .clk       (clk),
    .reset     (reset),
    .flush_req (flush_req),
    .instr     (instr),
    .ctrl      (ctrl),
    .advance   (advance)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ==============================
  // Golden file
  // ==============================

  function automatic logic [63:0] golden_word(input int idx);
    return golden_mem[idx[GOLDEN_AW-1:0]];
  endfunction

  task automatic load_golden();
    int fd;
    int a;
    int v;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the golden file %s", GOLDEN_FILE);
      file_errors++;
    end else begin
      $fclose(fd);
      // Unwritten words hold a value that no column can take
      for (a = 0; a < GOLDEN_WORDS; a++) begin
        golden_mem[a[GOLDEN_AW-1:0]] = ~64'(a);
      end
      $readmemh(GOLDEN_FILE, golden_mem);
      while (vec_count < MAX_VECTORS && golden_word(4 * vec_count) <= 64'd1) begin
        vec_count++;
      end
      if (vec_count == 0) begin
        $display("The golden file %s holds no vectors", GOLDEN_FILE);
        file_errors++;
      end
      for (v = 0; v < vec_count; v++) begin
        if (golden_word(4 * v + 3) > 64'd1) begin
          $display("Golden vector %0d is cut short or has a bad advance column", v);
          file_errors++;
        end
      end
    end
  endtask

  // ==============================
  // Compare tasks
  // ==============================

  task automatic check_ctrl(input ctrl_word_t actual, input ctrl_word_t expected,
                            input int vec);
    if (actual !== expected) begin
      $display("** Error: ctrl = %h, expected %h (vector %0d)", actual, expected, vec);
      ctrl_errors++;
    end
  endtask

  task automatic check_advance(input logic actual, input logic expected, input int vec);
    if (actual !== expected) begin
      $display("** Error: advance = %h, expected %h (vector %0d)", actual, expected, vec);
      advance_errors++;
    end
  endtask

  // Ends the run if the stimulus loop stalls
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Errors: %0d ctrl, %0d advance, %0d golden file",
               ctrl_errors, advance_errors, file_errors);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    int          v;
    logic [63:0] vec_word;
    ctrl_word_t  exp_ctrl;
    logic        exp_advance;
    reset     = 1'b1;
    flush_req = 1'b0;
    instr     = '0;
    load_golden();
    if (file_errors == 0) begin
      cycle_limit = RESET_CYCLES + vec_count + TIMEOUT_SLACK;
      repeat (RESET_CYCLES) @(posedge clk);
      for (v = 0; v < vec_count; v++) begin
        @(negedge clk);
        reset       = 1'b0;
        vec_word    = golden_word(4 * v);
        flush_req   = vec_word != 64'd0;
        vec_word    = golden_word(4 * v + 1);
        instr       = vec_word[INSTR_W-1:0];
        vec_word    = golden_word(4 * v + 2);
        exp_ctrl    = vec_word[CTRL_W-1:0];
        vec_word    = golden_word(4 * v + 3);
        exp_advance = vec_word[0];
        // Sample just ahead of the next rising edge
        #(CLK_PERIOD / 2 - 1);
        check_ctrl(ctrl, exp_ctrl, v);
        check_advance(advance, exp_advance, v);
      end
    end
    $display("Errors: %0d ctrl, %0d advance, %0d golden file",
             ctrl_errors, advance_errors, file_errors);
    if (ctrl_errors + advance_errors + file_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           flush_req,
  input  cpu_decode_pkg::decoded_instr_t instr,
  output cpu_control_pkg::ctrl_word_t    ctrl,
  output logic                           advance
);

  import cpu_control_pkg::*;

  ctrl_word_t flush_word;
  ctrl_word_t dp_word;
  ctrl_word_t ls_word;
  logic       flush_active;
  logic       flush_advance;
  logic       dp_done;
  logic       ls_done;
  step_t      step;

  flush_sequencer flush_i (
    .clk           (clk),
    .reset         (reset),
    .flush_req     (flush_req),
    .flush_word    (flush_word),
    .flush_active  (flush_active),
    .flush_advance (flush_advance)
  );

  dataproc_control dp_i (
    .instr   (instr),
    .step    (step),
    .dp_word (dp_word),
    .dp_done (dp_done)
  );

  load_store_control ls_i (
    .instr   (instr),
    .step    (step),
    .ls_word (ls_word),
    .ls_done (ls_done)
  );

  control_sequencer seq_i (
    .clk           (clk),
    .reset         (reset),
    .instr         (instr),
    .flush_word    (flush_word),
    .flush_active  (flush_active),
    .flush_advance (flush_advance),
    .dp_word       (dp_word),
    .dp_done       (dp_done),
    .ls_word       (ls_word),
    .ls_done       (ls_done),
    .step          (step),
    .ctrl          (ctrl),
    .advance       (advance)
  );

endmodule

`default_nettype wire

/* src/control_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module control_sequencer (
  input  logic                           clk,
  input  logic                           reset,
  input  cpu_decode_pkg::decoded_instr_t instr,
  input  cpu_control_pkg::ctrl_word_t    flush_word,
  input  logic                           flush_active,
  input  logic                           flush_advance,
  input  cpu_control_pkg::ctrl_word_t    dp_word,
  input  logic                           dp_done,
  input  cpu_control_pkg::ctrl_word_t    ls_word,
  input  logic                           ls_done,
  output cpu_control_pkg::step_t         step,
  output cpu_control_pkg::ctrl_word_t    ctrl,
  output logic                           advance
);

  import cpu_decode_pkg::*;
  import cpu_control_pkg::*;

  logic use_dp;
  logic use_ls;

  always_ff @(posedge clk) begin
    if (reset || advance) begin
      step <= '0;
    end else begin
      step <= step + step_t'(1);
    end
  end

  // Failed conditions and unsupported classes select neither controller
  always_comb begin
    use_dp = 1'b0;
    use_ls = 1'b0;
    case (instr.instr_class)
      CLASS_DP_IMM, CLASS_DP_REG_IMM, CLASS_DP_REG_REG: use_dp = instr.condition_pass;
      CLASS_LOAD, CLASS_STORE:                          use_ls = instr.condition_pass;
      default: ;
    endcase
  end

  always_comb begin
    ctrl    = '0;
    advance = 1'b0;
    if (flush_active) begin
      ctrl    = flush_word;
      advance = flush_advance;
    end else if (use_dp) begin
      ctrl    = dp_word;
      advance = dp_done;
    end else if (use_ls) begin
      ctrl    = ls_word;
      advance = ls_done;
    end else begin
      // Skip, fetch the next instruction and retire this one
      ctrl.fetch_en       = 1'b1;
      ctrl.incr_writeback = 1'b1;
      ctrl.addr_src       = ADDR_SRC_PC;
      advance             = 1'b1;
    end
  end

  // Only a flush can outlast the longest instruction
  step_in_range: assert property (
    @(posedge clk) disable iff (reset) !flush_active |-> step != step_t'(3)
  );

endmodule

`default_nettype wire

/* src/load_store_control.sv */
`timescale 1ns/1ps
`default_nettype none

module load_store_control (
  input  cpu_decode_pkg::decoded_instr_t instr,
  input  cpu_control_pkg::step_t         step,
  output cpu_control_pkg::ctrl_word_t    ls_word,
  output logic                           ls_done
);

  import cpu_decode_pkg::*;
  import cpu_control_pkg::*;

  logic    is_load;
  logic    is_store;
  logic    base_wb;
  alu_op_e addr_op;

  assign is_load  = instr.instr_class == CLASS_LOAD;
  assign is_store = instr.instr_class == CLASS_STORE;

  // Post-index always updates the base, pre-index only with W set
  assign base_wb = !instr.pre || instr.writeback;
  assign addr_op = instr.up ? ALU_OP_ADD : ALU_OP_SUB;

  always_comb begin
    ls_word = '0;
    ls_done = 1'b0;
    if (is_load || is_store) begin
      case (step)
        // =============================
        // Address calculation
        // =============================
        step_t'(0): begin
          // Prefetch overlaps the address calculation
          ls_word.fetch_en       = 1'b1;
          ls_word.incr_writeback = 1'b1;
          ls_word.addr_src       = ADDR_SRC_ALU;
          ls_word.alu_op         = addr_op;
          if (instr.pre) begin
            ls_word.alu_latch_op_b = instr.writeback;
          end else begin
            // Post-index addresses with the bare base, offset kept for writeback
            ls_word.alu_disable_op_b = 1'b1;
            ls_word.alu_latch_op_b   = 1'b1;
          end
          if (instr.imm_offset) begin
            ls_word.b_src        = B_SRC_IMM;
            ls_word.b_imm        = instr.offset12;
            ls_word.shift_type   = SHIFT_LSL;
            ls_word.shift_amount = '0;
          end else begin
            ls_word.b_src         = B_SRC_RM;
            ls_word.shift_type    = instr.shift_type;
            ls_word.shift_amount  = instr.shift_amount;
            ls_word.shift_use_rrx = instr.shift_type == SHIFT_ROR &&
                                    instr.shift_amount == '0;
          end
        end
        // =============================
        // Memory access
        // =============================
        step_t'(1): begin
          ls_word.mem_byte = instr.byte_xfer;
          ls_word.addr_src = ADDR_SRC_PC;
          if (base_wb) begin
            ls_word.alu_op             = addr_op;
            ls_word.alu_use_op_b_latch = 1'b1;
            ls_word.alu_wb             = ALU_WB_RN;
          end
          if (is_load) begin
            ls_word.mem_read_en = 1'b1;
          end else begin
            ls_word.b_src        = B_SRC_RD;
            ls_word.mem_write_en = 1'b1;
            ls_done              = 1'b1;
          end
        end
        step_t'(2): begin
          // Load data passes the ALU unchanged into rd
          if (is_load) begin
            ls_word.b_src    = B_SRC_READ_DATA;
            ls_word.alu_op   = ALU_OP_MOV;
            ls_word.alu_wb   = ALU_WB_RD;
            ls_word.mem_byte = instr.byte_xfer;
            ls_word.addr_src = ADDR_SRC_PC;
            ls_done          = 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    rw_exclusive: assert (!(ls_word.mem_read_en && ls_word.mem_write_en))
      else $error("memory read and write requested in the same step");
  end

endmodule

`default_nettype wire

/* src/dataproc_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module dataproc_control (
  input  cpu_decode_pkg::decoded_instr_t instr,
  input  cpu_control_pkg::step_t         step,
  output cpu_control_pkg::ctrl_word_t    dp_word,
  output logic                           dp_done
);

  import cpu_decode_pkg::*;
  import cpu_control_pkg::*;

  localparam reg_idx_t PC_IDX = reg_idx_t'(`CPU_PC_IDX);

  alu_op_e dp_op;
  alu_wb_e dp_wb;

  assign dp_op = alu_op_e'({1'b0, instr.opcode});

  // Compare opcodes only update the flags
  always_comb begin
    case (dp_op)
      ALU_OP_TST, ALU_OP_TEQ, ALU_OP_CMP, ALU_OP_CMN: dp_wb = ALU_WB_NONE;
      default:                                        dp_wb = ALU_WB_RD;
    endcase
  end

  always_comb begin
    logic finish;
    finish  = 1'b0;
    dp_word = '0;
    dp_done = 1'b0;
    case (instr.instr_class)
      CLASS_DP_IMM: begin
        // 8-bit immediate rotated right by twice the rotate field
        dp_word.b_src        = B_SRC_IMM;
        dp_word.b_imm        = b_imm_t'(instr.imm8);
        dp_word.shift_type   = SHIFT_ROR;
        dp_word.shift_amount = {instr.rotate, 1'b0};
        finish               = 1'b1;
      end
      CLASS_DP_REG_IMM: begin
        dp_word.b_src         = B_SRC_RM;
        dp_word.shift_type    = instr.shift_type;
        dp_word.shift_amount  = instr.shift_amount;
        // ROR #0 encodes RRX
        dp_word.shift_use_rrx = instr.shift_type == SHIFT_ROR && instr.shift_amount == '0;
        finish                = 1'b1;
      end
      CLASS_DP_REG_REG: begin
        if (step == step_t'(0)) begin
          // Internal cycle reading the shift amount from rs
          dp_word.b_src           = B_SRC_RS;
          dp_word.shift_latch_amt = 1'b1;
          dp_word.pc_rs_add_4     = instr.rs == PC_IDX;
        end else if (step == step_t'(1)) begin
          dp_word.b_src           = B_SRC_RM;
          dp_word.shift_use_latch = 1'b1;
          dp_word.shift_type      = instr.shift_type;
          dp_word.pc_rn_add_4     = instr.rn == PC_IDX;
          dp_word.pc_rm_add_4     = instr.rm == PC_IDX;
          finish                  = 1'b1;
        end
      end
      default: ;
    endcase

    // Last step executes the opcode and fetches the next instruction
    if (finish) begin
      dp_word.alu_op         = dp_op;
      dp_word.alu_wb         = dp_wb;
      dp_word.alu_set_flags  = instr.set_flags;
      dp_word.fetch_en       = 1'b1;
      dp_word.incr_writeback = 1'b1;
      dp_word.addr_src       = ADDR_SRC_PC;
      dp_done                = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* src/flush_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module flush_sequencer (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        flush_req,
  output cpu_control_pkg::ctrl_word_t flush_word,
  output logic                        flush_active,
  output logic                        flush_advance
);

  import cpu_control_pkg::*;

  localparam logic [`CTRL_FLUSH_W-1:0] FLUSH_START = `CTRL_FLUSH_W'(`CTRL_FLUSH_START);

  logic [`CTRL_FLUSH_W-1:0] flush_cnt;

  // Reset loads a full flush while a request loads only fetch and refill
  always_ff @(posedge clk) begin
    if (reset) begin
      flush_cnt <= FLUSH_START;
    end else if (flush_req) begin
      flush_cnt <= `CTRL_FLUSH_W'(1);
    end else if (flush_cnt != '0) begin
      flush_cnt <= flush_cnt - `CTRL_FLUSH_W'(1);
    end
  end

  always_comb begin
    flush_word    = '0;
    flush_active  = 1'b0;
    flush_advance = 1'b0;
    if (flush_cnt == FLUSH_START) begin
      // Hold cycle puts the PC on the address bus
      flush_word.addr_src = ADDR_SRC_PC;
      flush_active        = 1'b1;
    end else if (flush_cnt == `CTRL_FLUSH_W'(2) || flush_req) begin
      flush_word.fetch_en       = 1'b1;
      flush_word.incr_writeback = 1'b1;
      flush_word.addr_src       = ADDR_SRC_INCR;
      flush_active              = 1'b1;
    end else if (flush_cnt == `CTRL_FLUSH_W'(1)) begin
      // Refill brings the first instruction to the decoder
      flush_word.fetch_en       = 1'b1;
      flush_word.incr_writeback = 1'b1;
      flush_word.addr_src       = ADDR_SRC_PC;
      flush_active              = 1'b1;
      flush_advance             = 1'b1;
    end
  end

  // The start value is only seen in the cycle right after reset
  start_only_after_reset: assert property (
    @(posedge clk) disable iff (reset) flush_cnt == FLUSH_START |-> $past(reset)
  );

endmodule

`default_nettype wire

/* src/cpu_control_pkg.sv */
`default_nettype none

`include "cpu_defs.svh"

package cpu_control_pkg;

  typedef logic [`CTRL_STEP_W-1:0] step_t;
  typedef logic [`CPU_IMM_W-1:0] b_imm_t;

  // The 16 ARM opcodes keep their encoding, extra operations follow
  typedef enum logic [4:0] {
    ALU_OP_AND          = 5'd0,
    ALU_OP_EOR          = 5'd1,
    ALU_OP_SUB          = 5'd2,
    ALU_OP_RSB          = 5'd3,
    ALU_OP_ADD          = 5'd4,
    ALU_OP_ADC          = 5'd5,
    ALU_OP_SBC          = 5'd6,
    ALU_OP_RSC          = 5'd7,
    ALU_OP_TST          = 5'd8,
    ALU_OP_TEQ          = 5'd9,
    ALU_OP_CMP          = 5'd10,
    ALU_OP_CMN          = 5'd11,
    ALU_OP_ORR          = 5'd12,
    ALU_OP_MOV          = 5'd13,
    ALU_OP_BIC          = 5'd14,
    ALU_OP_MVN          = 5'd15,
    ALU_OP_SUB_REVERSED = 5'd16
  } alu_op_e;

  typedef enum logic [1:0] {
    ADDR_SRC_PC   = 2'd0,
    ADDR_SRC_INCR = 2'd1,
    ADDR_SRC_ALU  = 2'd2
  } addr_src_e;

  typedef enum logic [2:0] {
    B_SRC_NONE      = 3'd0,
    B_SRC_IMM       = 3'd1,
    B_SRC_RM        = 3'd2,
    B_SRC_RS        = 3'd3,
    B_SRC_RD        = 3'd4,
    B_SRC_READ_DATA = 3'd5
  } b_src_e;

  typedef enum logic [1:0] {
    ALU_WB_NONE = 2'd0,
    ALU_WB_RD   = 2'd1,
    ALU_WB_RN   = 2'd2
  } alu_wb_e;

  typedef struct packed {
    // Operand path
    addr_src_e                  addr_src;
    b_src_e                     b_src;
    b_imm_t                     b_imm;
    cpu_decode_pkg::shift_e     shift_type;
    cpu_decode_pkg::shift_amt_t shift_amount;
    logic                       shift_latch_amt;
    logic                       shift_use_latch;
    logic                       shift_use_rrx;
    // ALU
    alu_op_e                    alu_op;
    alu_wb_e                    alu_wb;
    logic                       alu_set_flags;
    logic                       alu_latch_op_b;
    logic                       alu_disable_op_b;
    logic                       alu_use_op_b_latch;
    // Register reads of the PC see it one word ahead
    logic                       pc_rn_add_4;
    logic                       pc_rm_add_4;
    logic                       pc_rs_add_4;
    // Memory and fetch
    logic                       mem_read_en;
    logic                       mem_write_en;
    logic                       mem_byte;
    logic                       fetch_en;
    logic                       incr_writeback;
  } ctrl_word_t;

endpackage

`default_nettype wire

/* src/cpu_decode_pkg.sv */
`default_nettype none

`include "cpu_defs.svh"

package cpu_decode_pkg;

  typedef logic [`CPU_REG_IDX_W-1:0] reg_idx_t;
  typedef logic [`CPU_SHIFT_AMT_W-1:0] shift_amt_t;
  typedef logic [`CPU_IMM_W-1:0] offset12_t;
  typedef logic [3:0] dp_opcode_t;

  typedef enum logic [1:0] {
    SHIFT_LSL = 2'd0,
    SHIFT_LSR = 2'd1,
    SHIFT_ASR = 2'd2,
    SHIFT_ROR = 2'd3
  } shift_e;

  // Classes the control unit sequences; anything else is skipped
  typedef enum logic [2:0] {
    CLASS_DP_IMM     = 3'd0,
    CLASS_DP_REG_IMM = 3'd1,
    CLASS_DP_REG_REG = 3'd2,
    CLASS_LOAD       = 3'd3,
    CLASS_STORE      = 3'd4,
    CLASS_OTHER      = 3'd5
  } instr_class_e;

  typedef struct packed {
    instr_class_e instr_class;
    logic         condition_pass;
    reg_idx_t     rn;
    reg_idx_t     rm;
    reg_idx_t     rs;
    dp_opcode_t   opcode;
    logic         set_flags;
    logic [7:0]   imm8;
    logic [3:0]   rotate;
    shift_e       shift_type;
    shift_amt_t   shift_amount;
    // Single transfer bits P, U, B, W and the inverted I bit
    logic         pre;
    logic         up;
    logic         byte_xfer;
    logic         writeback;
    logic         imm_offset;
    offset12_t    offset12;
  } decoded_instr_t;

endpackage

`default_nettype wire

/* src/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Register file
`define CPU_REG_IDX_W 4
`define CPU_PC_IDX 15

// Operand field widths
`define CPU_SHIFT_AMT_W 5
`define CPU_IMM_W 12

// Control unit sequencing
`define CTRL_STEP_W 2

// Counter value loaded at reset, giving hold, fetch and refill cycles
`define CTRL_FLUSH_START 3
`define CTRL_FLUSH_W 2

`endif
